//--- hw/pdp8_defines.svh
`ifndef PDP8_DEFINES_SVH
`define PDP8_DEFINES_SVH

// Bit 0 of a word is the most significant bit
`define PDP8_WORD_BITS      12
`define PDP8_PAGE_BITS      5
`define PDP8_OFFSET_BITS    7

// OPR group 1 with no bits set is a NOP
`define PDP8_RESET_INSTR    12'o7000

// Locations that auto-increment when used as a pointer
`define PDP8_AUTOINDEX_FIRST 12'o0010
`define PDP8_AUTOINDEX_LAST  12'o0017

`endif

//--- hw/pdp8_pkg.sv
`default_nettype none

`include "pdp8_defines.svh"

package pdp8_pkg;

    typedef logic [0:`PDP8_WORD_BITS-1]   word_t;    // Data word or address
    typedef logic [0:`PDP8_PAGE_BITS-1]   page_t;    // Page number
    typedef logic [0:`PDP8_OFFSET_BITS-1] offset_t;  // Word within a page

    typedef enum logic [0:2] {
        AND = 3'o0,
        TAD = 3'o1,
        ISZ = 3'o2,
        DCA = 3'o3,
        JMS = 3'o4,
        JMP = 3'o5,
        IOT = 3'o6,
        OPR = 3'o7
    } opcode_t;

    // Five states per major cycle
    typedef enum logic [4:0] {
        F0, FW, F1, F2, F3,
        D0, DW, D1, D2, D3,
        E0, EW, E1, E2, E3,
        H0, HW, H1, H2, H3
    } major_state_t;

    typedef enum logic [2:0] {
        NONE,
        LOAD_ADDR,
        DEPOSIT,
        EXAMINE,
        RUN
    } panel_cmd_t;

endpackage

`default_nettype wire

//--- hw/core_mem_if.sv
`default_nettype none

interface core_mem_if
    import pdp8_pkg::*;
();

    word_t addr;      // Registered by the memory every clock
    word_t wdata;
    logic  write_en;
    word_t rdata;     // Word at the previously registered address

    modport controller (output addr, output wdata, output write_en, input rdata);
    modport memory (input addr, input wdata, input write_en, output rdata);

endinterface

`default_nettype wire

//--- hw/core_memory.sv
`default_nettype none

`include "pdp8_defines.svh"

module core_memory
    import pdp8_pkg::*;
(
    input  logic           clk,
    core_mem_if.memory     mem
);

    localparam int DEPTH = 1 << `PDP8_WORD_BITS;

    word_t core [0:DEPTH-1];
    word_t addr_q;                       // Read address for the one-cycle latency

    always_ff @(posedge clk) begin
        if (mem.write_en) begin
            core[mem.addr] <= mem.wdata;
        end
        addr_q <= mem.addr;
    end

    assign mem.rdata = core[addr_q];

endmodule

`default_nettype wire

//--- hw/major_state_sequencer.sv
`default_nettype none

module major_state_sequencer
    import pdp8_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         load_addr,
    input  logic         deposit,
    input  logic         examine,
    input  logic         run,
    input  word_t        instruction,
    output major_state_t state,
    output panel_cmd_t   panel_cmd,
    output logic         halted,
    output logic         panel_ready
);

    major_state_t state_q;
    major_state_t state_d;
    panel_cmd_t   cmd_q;
    logic         cmd_armed;             // Set at H0 so the command runs in this halt cycle
    opcode_t      opcode;
    logic         indirect;
    logic         hlt_word;

    assign opcode   = opcode_t'(instruction[0:2]);
    assign indirect = instruction[3];
    // Group 2 operate with the HLT bit
    assign hlt_word = (opcode == OPR) && instruction[3] && !instruction[11]
                      && instruction[10];

    always_comb begin
        case (state_q)
            F0: state_d = FW;
            FW: state_d = F1;
            F1: state_d = F2;
            F2: state_d = F3;
            F3: begin
                if (opcode == OPR || opcode == IOT) begin
                    state_d = hlt_word ? H0 : F0;
                end else if (indirect) begin
                    state_d = D0;
                end else if (opcode == JMP) begin
                    state_d = F0;        // Direct JMP needs no operand
                end else begin
                    state_d = E0;
                end
            end
            D0: state_d = DW;
            DW: state_d = D1;
            D1: state_d = D2;
            D2: state_d = D3;
            D3: state_d = (opcode == JMP) ? F0 : E0;
            E0: state_d = EW;
            EW: state_d = E1;
            E1: state_d = E2;
            E2: state_d = E3;
            E3: state_d = F0;
            H0: state_d = HW;
            HW: state_d = H1;
            H1: state_d = H2;
            H2: state_d = H3;
            H3: state_d = (cmd_armed && cmd_q == RUN) ? F0 : H0;
            default: state_d = H0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= H0;
        end else begin
            state_q <= state_d;
        end
    end

    // One-entry panel command register
    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_q     <= NONE;
            cmd_armed <= 1'b0;
        end else if (state_q == H3 && cmd_armed) begin
            cmd_q     <= NONE;           // Command done
            cmd_armed <= 1'b0;
        end else if (state_q == H0 && cmd_q != NONE) begin
            cmd_armed <= 1'b1;
        end else if (panel_ready) begin
            if (load_addr) begin
                cmd_q <= LOAD_ADDR;
            end else if (deposit) begin
                cmd_q <= DEPOSIT;
            end else if (examine) begin
                cmd_q <= EXAMINE;
            end else if (run) begin
                cmd_q <= RUN;
            end
        end
    end

    assign state       = state_q;
    assign panel_cmd   = cmd_armed ? cmd_q : NONE;
    assign halted      = state_q inside {H0, HW, H1, H2, H3};
    assign panel_ready = halted && (cmd_q == NONE);

endmodule

`default_nettype wire

//--- hw/accumulator_unit.sv
`default_nettype none

module accumulator_unit
    import pdp8_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  major_state_t state,
    input  word_t        instruction,
    input  word_t        md,
    output word_t        ac,
    output logic         link,
    output logic         skip
);

    opcode_t       opcode;
    logic          group2;
    word_t         opr_ac;
    logic          opr_link;
    logic [0:12]   tad_sum;              // Bit 0 is the carry
    logic          skip_cond;

    assign opcode = opcode_t'(instruction[0:2]);
    assign group2 = (opcode == OPR) && instruction[3] && !instruction[11];

    // Group 1 in order of clear, complement and increment
    always_comb begin
        opr_ac   = instruction[4] ? '0 : ac;
        opr_link = instruction[5] ? 1'b0 : link;
        if (instruction[6]) begin
            opr_ac = ~opr_ac;
        end
        if (instruction[7]) begin
            opr_link = ~opr_link;
        end
        if (instruction[11]) begin
            {opr_link, opr_ac} = {opr_link, opr_ac} + 13'd1;
        end
    end

    assign tad_sum = {1'b0, ac} + {1'b0, md};

    // SMA, SZA and SNL ored and inverted by the reverse-sense bit
    assign skip_cond = ((instruction[5] && ac[0])
                        || (instruction[6] && ac == '0)
                        || (instruction[7] && link)) ^ instruction[8];

    always_ff @(posedge clk) begin
        if (reset) begin
            ac   <= '0;
            link <= 1'b0;
            skip <= 1'b0;
        end else begin
            case (state)
                F2: begin
                    skip <= group2 && skip_cond;   // Held for the address unit in F3
                    if (opcode == OPR && !instruction[3]) begin
                        ac   <= opr_ac;
                        link <= opr_link;
                    end else if (group2 && instruction[4]) begin
                        ac <= '0;                  // Group 2 CLA after the test
                    end
                end
                E2: begin
                    case (opcode)
                        AND: ac <= ac & md;
                        TAD: begin
                            ac   <= tad_sum[1:12];
                            link <= link ^ tad_sum[0];
                        end
                        DCA: ac <= '0;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/memory_address_unit.sv
`default_nettype none

`include "pdp8_defines.svh"

module memory_address_unit
    import pdp8_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  major_state_t   state,
    input  panel_cmd_t     panel_cmd,
    input  word_t          sr,
    input  word_t          ac,
    input  logic           skip,
    core_mem_if.controller mem,
    output word_t          instruction,
    output word_t          md,
    output word_t          pc,
    output word_t          mem_addr
);

    page_t   current_page;
    word_t   next_pc;
    word_t   skip_pc;
    word_t   idx_tmp;                    // Incremented auto-index pointer
    word_t   wdata;
    word_t   operand_addr;
    logic    write_en;
    logic    index;
    opcode_t opcode;
    offset_t offset;

    assign opcode = opcode_t'(instruction[0:2]);
    assign offset = instruction[5:11];
    // Bit 4 selects the current page over page zero
    assign operand_addr = instruction[4] ? {current_page, offset}
                                         : {page_t'(0), offset};

    assign mem.addr     = mem_addr;
    assign mem.wdata    = wdata;
    assign mem.write_en = write_en;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_addr    <= '0;
            pc          <= '0;
            md          <= '0;
            instruction <= `PDP8_RESET_INSTR;
            write_en    <= 1'b0;
            index       <= 1'b0;
        end else begin
            write_en <= 1'b0;
            case (state)
                F0: pc <= mem_addr;
                FW: begin
                    md          <= mem.rdata;
                    instruction <= mem.rdata;
                end
                F2: begin
                    current_page <= pc[0:`PDP8_PAGE_BITS-1];
                    next_pc      <= pc + 12'o0001;
                    skip_pc      <= pc + 12'o0002;
                end
                F3: begin
                    if (opcode != OPR && opcode != IOT) begin
                        mem_addr <= operand_addr;
                        if (opcode == JMP) begin
                            pc <= operand_addr;
                        end else begin
                            pc <= next_pc;
                        end
                    end else if (opcode == OPR && skip) begin
                        mem_addr <= skip_pc;
                        pc       <= skip_pc;
                    end else begin
                        mem_addr <= next_pc;
                        pc       <= next_pc;
                    end
                end
                D0: index <= (mem_addr >= `PDP8_AUTOINDEX_FIRST)
                             && (mem_addr <= `PDP8_AUTOINDEX_LAST);
                DW: md <= mem.rdata;
                D1: begin
                    if (index) begin
                        wdata    <= md + 12'o0001;   // Pointer written back in D2
                        idx_tmp  <= md + 12'o0001;
                        write_en <= 1'b1;
                    end
                end
                D3: begin
                    mem_addr <= index ? idx_tmp : md;
                    index    <= 1'b0;
                    if (opcode == JMP) begin
                        pc <= index ? idx_tmp : md;
                    end
                end
                EW: md <= mem.rdata;
                E1: begin
                    case (opcode)
                        ISZ: begin
                            wdata    <= md + 12'o0001;
                            write_en <= 1'b1;
                            if (md == 12'o7777) begin
                                next_pc <= skip_pc;
                            end
                        end
                        JMS: begin
                            wdata    <= next_pc;     // Return address
                            write_en <= 1'b1;
                        end
                        DCA: begin
                            wdata    <= ac;
                            write_en <= 1'b1;
                        end
                        default: ;
                    endcase
                end
                E2: begin
                    if (opcode == JMS) begin
                        next_pc <= mem_addr + 12'o0001;
                    end
                end
                E3: mem_addr <= next_pc;
                HW: begin
                    if (panel_cmd == EXAMINE) begin
                        md <= mem.rdata;
                    end
                end
                H1: begin
                    if (panel_cmd == LOAD_ADDR) begin
                        mem_addr <= sr;
                    end else if (panel_cmd == DEPOSIT) begin
                        wdata    <= sr;
                        write_en <= 1'b1;
                    end
                end
                H2: begin
                    if (panel_cmd == DEPOSIT || panel_cmd == EXAMINE) begin
                        mem_addr <= mem_addr + 12'o0001;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/pdp8_core.sv
`default_nettype none

module pdp8_core
    import pdp8_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  word_t sr,            // Switch register
    input  logic  load_addr,
    input  logic  deposit,
    input  logic  examine,
    input  logic  run,
    output word_t ac,
    output logic  link,
    output word_t pc,
    output word_t mem_addr,
    output word_t md,
    output logic  halted,
    output logic  panel_ready
);

    major_state_t state;
    panel_cmd_t   panel_cmd;
    word_t        instruction;
    logic         skip;

    core_mem_if mem_bus ();

    major_state_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .load_addr   (load_addr),
        .deposit     (deposit),
        .examine     (examine),
        .run         (run),
        .instruction (instruction),
        .state       (state),
        .panel_cmd   (panel_cmd),
        .halted      (halted),
        .panel_ready (panel_ready)
    );

    accumulator_unit u_accumulator (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .instruction (instruction),
        .md          (md),
        .ac          (ac),
        .link        (link),
        .skip        (skip)
    );

    memory_address_unit u_address (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .panel_cmd   (panel_cmd),
        .sr          (sr),
        .ac          (ac),
        .skip        (skip),
        .mem         (mem_bus.controller),
        .instruction (instruction),
        .md          (md),
        .pc          (pc),
        .mem_addr    (mem_addr)
    );

    core_memory u_memory (
        .clk (clk),
        .mem (mem_bus.memory)
    );

endmodule

`default_nettype wire

//--- verification/pdp8_core_tb.sv
`default_nettype none

module pdp8_core_tb;

    typedef enum int {
        DO_LOAD,
        DO_DEPOSIT,
        DO_EXAMINE,
        DO_RUN,
        WAIT_HALT,
        CHECK_AC,
        CHECK_LINK,
        CHECK_PC,
        CHECK_MD,
        CHECK_ADDR
    } step_kind_t;

    localparam int MAX_STEPS    = 1024;
    localparam int MAX_PROG_LEN = 16;        // Bound on the instructions of one program
    localparam int MARGIN       = 500;

    logic        clk;
    logic        reset;
    logic [11:0] sr;
    logic        load_addr;
    logic        deposit;
    logic        examine;
    logic        run;
    logic [11:0] ac;
    logic        link;
    logic [11:0] pc;
    logic [11:0] mem_addr;
    logic [11:0] md;
    logic        halted;
    logic        panel_ready;

    step_kind_t  step_kind [MAX_STEPS];
    logic [11:0] step_value [MAX_STEPS];
    int          n_steps;
    int          cycle_count;
    int          cycle_limit;
    logic [15:0] lfsr;

    pdp8_core uut (
        .clk         (clk),
        .reset       (reset),
        .sr          (sr),
        .load_addr   (load_addr),
        .deposit     (deposit),
        .examine     (examine),
        .run         (run),
        .ac          (ac),
        .link        (link),
        .pc          (pc),
        .mem_addr    (mem_addr),
        .md          (md),
        .halted      (halted),
        .panel_ready (panel_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Run stopped at the limit of %0d clock cycles without finishing",
                     cycle_limit);
            $display("tests failed");
            $fatal(1);
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        lfsr_next = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);   // Galois form
    endfunction

    // One LFSR step for every bit of the word
    function automatic logic [11:0] random_word();
        logic [11:0] value;
        int          i;
        value = '0;
        for (i = 0; i < 12; i++) begin
            value = {value[10:0], lfsr[0]};
            lfsr  = lfsr_next(lfsr);
        end
        random_word = value;
    endfunction

    function automatic logic [12:0] add_with_carry(input logic [11:0] a, input logic [11:0] b);
        add_with_carry = {1'b0, a} + {1'b0, b};    // Bit 12 is the carry
    endfunction

    // SMA, SZA and SNL ored and inverted by the reverse-sense bit
    function automatic logic skip_taken(input logic [11:0] opr, input logic [11:0] acc,
                                        input logic lnk);
        logic cond;
        cond = (opr[6] && acc[11]) || (opr[5] && acc == 12'o0000) || (opr[4] && lnk);
        skip_taken = cond ^ opr[3];
    endfunction

    function automatic logic [11:0] skip_word(input int n);
        case (n)
            0: skip_word = 12'o7500;         // SMA
            1: skip_word = 12'o7440;         // SZA
            2: skip_word = 12'o7420;         // SNL
            3: skip_word = 12'o7510;         // SPA
            4: skip_word = 12'o7450;         // SNA
            5: skip_word = 12'o7430;         // SZL
            6: skip_word = 12'o7560;         // SMA SZA SNL
            default: skip_word = 12'o7570;   // SPA SNA SZL
        endcase
    endfunction

    task automatic add_step(input step_kind_t kind, input logic [11:0] value);
        step_kind[n_steps]  = kind;
        step_value[n_steps] = value;
        n_steps++;
    endtask

    task automatic wait_ready();
        @(negedge clk);
        while (!panel_ready) begin
            @(negedge clk);
        end
    endtask

    task automatic press_switch(input step_kind_t kind, input logic [11:0] value);
        wait_ready();
        @(posedge clk);
        sr <= value;
        case (kind)
            DO_LOAD:    load_addr <= 1'b1;
            DO_DEPOSIT: deposit   <= 1'b1;
            DO_EXAMINE: examine   <= 1'b1;
            default:    run       <= 1'b1;
        endcase
        @(posedge clk);
        load_addr <= 1'b0;
        deposit   <= 1'b0;
        examine   <= 1'b0;
        run       <= 1'b0;
        if (kind != DO_RUN) begin
            wait_ready();                    // Command finished
        end
    endtask

    task automatic check_value(input string name, input logic [11:0] actual,
                               input logic [11:0] expected);
        assert (actual === expected) else begin
            $display("[ERROR] %0t: %s is %04o, expected %04o", $time, name, actual, expected);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic build_table();
        logic [11:0] a;
        logic [11:0] b;
        logic [11:0] v;
        logic [11:0] opr;
        logic [11:0] ptr_data [2];
        logic [12:0] sum;
        int          r;
        int          s;
        int          k;
        lfsr = 16'd27;
        add_step(CHECK_AC, 12'o0000);
        add_step(CHECK_PC, 12'o0000);
        add_step(CHECK_ADDR, 12'o0000);
        // Deposit three words and read them back
        add_step(DO_LOAD, 12'o0100);
        add_step(DO_DEPOSIT, 12'o1234);
        add_step(DO_DEPOSIT, 12'o4321);
        add_step(DO_DEPOSIT, 12'o7070);
        add_step(CHECK_ADDR, 12'o0103);
        add_step(DO_LOAD, 12'o0100);
        add_step(DO_EXAMINE, 12'o0000);
        add_step(CHECK_MD, 12'o1234);
        add_step(CHECK_ADDR, 12'o0101);
        add_step(DO_EXAMINE, 12'o0000);
        add_step(CHECK_MD, 12'o4321);
        add_step(CHECK_ADDR, 12'o0102);
        add_step(DO_EXAMINE, 12'o0000);
        add_step(CHECK_MD, 12'o7070);
        add_step(CHECK_ADDR, 12'o0103);
        // CLA CLL, TAD A, TAD B, DCA C, TAD C, HLT
        add_step(DO_LOAD, 12'o0200);
        add_step(DO_DEPOSIT, 12'o7300);
        add_step(DO_DEPOSIT, 12'o1250);
        add_step(DO_DEPOSIT, 12'o1251);
        add_step(DO_DEPOSIT, 12'o3252);
        add_step(DO_DEPOSIT, 12'o1252);
        add_step(DO_DEPOSIT, 12'o7402);
        for (r = 0; r < 3; r++) begin
            a   = random_word();
            b   = random_word();
            sum = add_with_carry(a, b);
            add_step(DO_LOAD, 12'o0250);
            add_step(DO_DEPOSIT, a);
            add_step(DO_DEPOSIT, b);
            add_step(DO_DEPOSIT, 12'o0000);
            add_step(DO_LOAD, 12'o0200);
            add_step(DO_RUN, 12'o0000);
            add_step(WAIT_HALT, 12'o0000);
            add_step(CHECK_AC, sum[11:0]);
            add_step(CHECK_LINK, {11'b0, sum[12]});
            add_step(CHECK_PC, 12'o0206);
            add_step(DO_LOAD, 12'o0252);
            add_step(DO_EXAMINE, 12'o0000);
            add_step(CHECK_MD, sum[11:0]);
        end
        // JMS to 0410 where ISZ of 7777 skips HLT and JMP I 0410 returns
        add_step(DO_LOAD, 12'o0400);
        add_step(DO_DEPOSIT, 12'o7300);
        add_step(DO_DEPOSIT, 12'o4210);
        add_step(DO_DEPOSIT, 12'o1222);
        add_step(DO_DEPOSIT, 12'o7402);
        add_step(DO_LOAD, 12'o0410);
        add_step(DO_DEPOSIT, 12'o0000);
        add_step(DO_DEPOSIT, 12'o2220);
        add_step(DO_DEPOSIT, 12'o7402);
        add_step(DO_DEPOSIT, 12'o1221);
        add_step(DO_DEPOSIT, 12'o5610);
        add_step(DO_LOAD, 12'o0420);
        add_step(DO_DEPOSIT, 12'o7777);
        add_step(DO_DEPOSIT, 12'o0055);
        add_step(DO_DEPOSIT, 12'o0100);
        add_step(DO_LOAD, 12'o0400);
        add_step(DO_RUN, 12'o0000);
        add_step(WAIT_HALT, 12'o0000);
        add_step(CHECK_AC, 12'o0155);
        add_step(CHECK_LINK, 12'o0000);
        add_step(CHECK_PC, 12'o0404);
        add_step(DO_LOAD, 12'o0410);
        add_step(DO_EXAMINE, 12'o0000);
        add_step(CHECK_MD, 12'o0402);        // Return address
        add_step(DO_LOAD, 12'o0420);
        add_step(DO_EXAMINE, 12'o0000);
        add_step(CHECK_MD, 12'o0000);
        // TAD I 0010 with auto-increment run twice
        ptr_data[0] = random_word();
        ptr_data[1] = random_word();
        add_step(DO_LOAD, 12'o0600);
        add_step(DO_DEPOSIT, 12'o7300);
        add_step(DO_DEPOSIT, 12'o1410);
        add_step(DO_DEPOSIT, 12'o7402);
        add_step(DO_LOAD, 12'o0010);
        add_step(DO_DEPOSIT, 12'o0647);
        add_step(DO_LOAD, 12'o0647);
        add_step(DO_DEPOSIT, 12'o0246);      // Read only if the pointer is not stepped
        add_step(DO_DEPOSIT, ptr_data[0]);
        add_step(DO_DEPOSIT, ptr_data[1]);
        for (r = 0; r < 2; r++) begin
            add_step(DO_LOAD, 12'o0600);
            add_step(DO_RUN, 12'o0000);
            add_step(WAIT_HALT, 12'o0000);
            add_step(CHECK_AC, ptr_data[r]);
            add_step(CHECK_PC, 12'o0603);
            add_step(DO_LOAD, 12'o0010);
            add_step(DO_EXAMINE, 12'o0000);
            add_step(CHECK_MD, 12'o0650 + 12'(r));
        end
        // CMA IAC negates the operand
        add_step(DO_LOAD, 12'o1000);
        add_step(DO_DEPOSIT, 12'o7300);
        add_step(DO_DEPOSIT, 12'o1250);
        add_step(DO_DEPOSIT, 12'o7041);
        add_step(DO_DEPOSIT, 12'o7402);
        for (r = 0; r < 3; r++) begin
            v   = (r == 0) ? 12'o0000 : random_word();
            sum = add_with_carry(~v, 12'o0001);
            add_step(DO_LOAD, 12'o1050);
            add_step(DO_DEPOSIT, v);
            add_step(DO_LOAD, 12'o1000);
            add_step(DO_RUN, 12'o0000);
            add_step(WAIT_HALT, 12'o0000);
            add_step(CHECK_AC, sum[11:0]);
            add_step(CHECK_LINK, {11'b0, sum[12]});
        end
        // A skipped marker TAD leaves ac at the operand
        add_step(DO_LOAD, 12'o1200);
        add_step(DO_DEPOSIT, 12'o7300);
        add_step(DO_DEPOSIT, 12'o1250);
        add_step(DO_DEPOSIT, 12'o7000);
        add_step(DO_DEPOSIT, 12'o7500);
        add_step(DO_DEPOSIT, 12'o1251);
        add_step(DO_DEPOSIT, 12'o7402);
        add_step(DO_LOAD, 12'o1251);
        add_step(DO_DEPOSIT, 12'o0001);      // Marker
        for (s = 0; s < 8; s++) begin
            opr = skip_word(s);
            for (k = 0; k < 6; k++) begin
                if (k / 2 == 0) begin
                    v = 12'o0000;
                end else if (k / 2 == 1) begin
                    v = random_word() | 12'o4000;
                end else begin
                    v = (random_word() & 12'o3777) | 12'o0001;
                end
                sum = add_with_carry(v, 12'o0001);
                add_step(DO_LOAD, 12'o1202);
                add_step(DO_DEPOSIT, (k % 2 == 1) ? 12'o7020 : 12'o7000);   // CML or NOP
                add_step(DO_DEPOSIT, opr);
                add_step(DO_LOAD, 12'o1250);
                add_step(DO_DEPOSIT, v);
                add_step(DO_LOAD, 12'o1200);
                add_step(DO_RUN, 12'o0000);
                add_step(WAIT_HALT, 12'o0000);
                add_step(CHECK_AC, skip_taken(opr, v, k % 2 == 1) ? v : sum[11:0]);
            end
        end
    endtask

    initial begin
        int i;
        reset       = 1'b1;
        sr          = '0;
        load_addr   = 1'b0;
        deposit     = 1'b0;
        examine     = 1'b0;
        run         = 1'b0;
        cycle_count = 0;
        n_steps     = 0;
        build_table();
        cycle_limit = n_steps * 15 * MAX_PROG_LEN + MARGIN;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("halted", {11'b0, halted}, 12'o0001);
        check_value("panel_ready", {11'b0, panel_ready}, 12'o0001);
        for (i = 0; i < n_steps; i++) begin
            case (step_kind[i])
                DO_LOAD, DO_DEPOSIT, DO_EXAMINE, DO_RUN: begin
                    press_switch(step_kind[i], step_value[i]);
                end
                WAIT_HALT:  wait_ready();
                CHECK_AC:   check_value("ac", ac, step_value[i]);
                CHECK_LINK: check_value("link", {11'b0, link}, step_value[i]);
                CHECK_PC:   check_value("pc", pc, step_value[i]);
                CHECK_MD:   check_value("md", md, step_value[i]);
                default:    check_value("mem_addr", mem_addr, step_value[i]);
            endcase
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+hw
hw/pdp8_pkg.sv
hw/core_mem_if.sv
hw/core_memory.sv
hw/major_state_sequencer.sv
hw/accumulator_unit.sv
hw/memory_address_unit.sv
hw/pdp8_core.sv
verification/pdp8_core_tb.sv
